// ==== nic_csr.sv ====
/*
 * MMIO register block. Every read is answered one cycle later, unknown
 * addresses return zero. Flow count and RX queue size are stored minus one.
 * A CONN_STATUS read clears the stored status, a capture in that cycle is lost.
 */
`timescale 1ns/1ps
`include "nic_macros.svh"

module nic_csr
    import nic_pkg::*;
(
    input  logic                         ccip_clk,
    input  logic                         reset,

    input  logic                         mmio_rd_valid,
    input  logic                         mmio_wr_valid,
    input  logic [`NIC_MMIO_ADDR_W-1:0]  mmio_addr,
    input  logic [`NIC_TID_W-1:0]        mmio_tid,
    input  mmio_data_u                   mmio_wr_data,
    input  logic                         conn_status_valid,
    input  conn_status_t                 conn_status_in,

    output logic                         mmio_rsp_valid,
    output logic [`NIC_TID_W-1:0]        mmio_rsp_tid,
    output logic [`NIC_MMIO_DATA_W-1:0]  mmio_rsp_data,

    output logic [`NIC_CL_ADDR_W-1:0]    mem_tx_addr,
    output logic [`NIC_CL_ADDR_W-1:0]    mem_rx_addr,
    output logic                         nic_start,
    output logic [`NIC_LMAX_FLOWS-1:0]   num_of_flows,
    output logic [`NIC_LMAX_RXQ-1:0]     rx_queue_size,
    output logic [`NIC_LMAX_BATCH-1:0]   tx_batch_size,
    output logic [`NIC_LMAX_POLL-1:0]    polling_rate,
    output logic                         nic_init,
    output logic                         conn_setup_valid,
    output conn_setup_frame_t            conn_setup_frame,

    nic_readback_if.csr                  rb
);

    localparam logic [127:0] AFU_ID = `NIC_AFU_ID;
    localparam logic [1:0] INIT_CYCLES = 2'd2;

    logic         wr_start;
    logic         wr_init;
    logic         wr_get_cnt;
    logic         wr_conn_setup;
    logic         rd_conn_status;
    logic [1:0]   init_cnt;
    logic [7:0]   cnt_sel_q;
    conn_status_t conn_status_q;
    mmio_word_t   rd_data;

    assign wr_start       = mmio_wr_valid && (mmio_addr == `NIC_A_START);
    assign wr_init        = mmio_wr_valid && (mmio_addr == `NIC_A_INIT);
    assign wr_get_cnt     = mmio_wr_valid && (mmio_addr == `NIC_A_GET_CNT);
    assign wr_conn_setup  = mmio_wr_valid && (mmio_addr == `NIC_A_CONN_SETUP);
    assign rd_conn_status = mmio_rd_valid && (mmio_addr == `NIC_A_CONN_STATUS);

    // ========================================================================
    // Configuration registers
    // ========================================================================
    always_ff @(posedge ccip_clk) begin
        if (mmio_wr_valid) begin
            case (mmio_addr)
                `NIC_A_TX_ADDR:    mem_tx_addr   <= mmio_wr_data.raw[`NIC_CL_ADDR_W-1:0];
                `NIC_A_RX_ADDR:    mem_rx_addr   <= mmio_wr_data.raw[`NIC_CL_ADDR_W-1:0];
                // Host writes the count, hardware keeps count - 1
                `NIC_A_FLOWS:      num_of_flows  <= mmio_wr_data.raw[`NIC_LMAX_FLOWS-1:0] - 1'b1;
                `NIC_A_RXQ:        rx_queue_size <= mmio_wr_data.raw[`NIC_LMAX_RXQ-1:0] - 1'b1;
                `NIC_A_TX_BATCH:   tx_batch_size <= mmio_wr_data.raw[`NIC_LMAX_BATCH-1:0];
                `NIC_A_POLL:       polling_rate  <= mmio_wr_data.raw[`NIC_LMAX_POLL-1:0];
                `NIC_A_CONN_SETUP: conn_setup_frame <= mmio_wr_data.frame;
                default: ;
            endcase
        end
    end

    // ========================================================================
    // Control state: start, counter select, init pulse, connection status
    // ========================================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            nic_start        <= 1'b0;
            cnt_sel_q        <= 8'd0;
            init_cnt         <= 2'd0;
            conn_setup_valid <= 1'b0;
            conn_status_q    <= '0;
            mmio_rsp_valid   <= 1'b0;
        end else begin
            if (wr_start) begin
                nic_start <= mmio_wr_data.raw[0];
            end
            if (wr_get_cnt) begin
                cnt_sel_q <= mmio_wr_data.raw[7:0];
            end

            // Init write arms a two-cycle pulse
            if (wr_init) begin
                init_cnt <= INIT_CYCLES;
            end else if (init_cnt != 2'd0) begin
                init_cnt <= init_cnt - 2'd1;
            end

            conn_setup_valid <= wr_conn_setup;

            // Clear on read wins over a new capture
            if (rd_conn_status) begin
                conn_status_q <= '0;
            end else if (conn_status_valid) begin
                conn_status_q <= conn_status_in;
            end

            mmio_rsp_valid <= mmio_rd_valid;
        end
    end

    assign nic_init   = (init_cnt != 2'd0);
    assign rb.cnt_sel = cnt_sel_q;

    // ========================================================================
    // Read multiplexer
    // ========================================================================
    always_comb begin
        rd_data = '0;
        case (mmio_addr)
            `NIC_A_DFH: begin
                // AFU feature type, single entry so end of list is set
                rd_data[63:60] = 4'h1;
                rd_data[40]    = 1'b1;
            end
            `NIC_A_AFU_ID_L:    rd_data = AFU_ID[63:0];
            `NIC_A_AFU_ID_H:    rd_data = AFU_ID[127:64];
            `NIC_A_STATUS:      rd_data = mmio_word_t'(rb.status);
            `NIC_A_RPS:         rd_data = mmio_word_t'(rb.rps);
            `NIC_A_PCK_CNT:     rd_data = rb.cnt_value;
            `NIC_A_CONN_STATUS: rd_data = mmio_word_t'(conn_status_q);
            default:            rd_data = '0;
        endcase
    end

    always_ff @(posedge ccip_clk) begin
        mmio_rsp_tid  <= mmio_tid;
        mmio_rsp_data <= rd_data;
    end

endmodule

// ==== nic_if.sv ====
/*
 * Event strobes from the transport and network layers, and the readback
 * path between the CSR block and the monitor and counter blocks.
 * Both carry plain levels and strobes, with no handshake.
 */
`timescale 1ns/1ps
`include "nic_macros.svh"

interface nic_event_if;
    logic rpc_in;
    logic rpc_out;
    logic net_tx;
    logic net_rx;

    modport src  (output rpc_in, rpc_out, net_tx, net_rx);
    modport sink (input  rpc_in, rpc_out, net_tx, net_rx);
endinterface

interface nic_readback_if import nic_pkg::*; ();
    nic_status_t            status;
    logic [`NIC_RATE_W-1:0] rps;
    logic [7:0]             cnt_sel;
    logic [`NIC_CNT_W-1:0]  cnt_value;

    modport csr (output cnt_sel, input status, rps, cnt_value);
    modport mon (output status, rps);
    modport cnt (input cnt_sel, output cnt_value);
endinterface

// ==== nic_macros.svh ====
/*
 * Widths, MMIO register offsets and constants of the NIC control plane.
 * Offsets address 32-bit MMIO words, so every 64-bit register sits on an even
 * offset. NIC_RPS_WINDOW is kept short here and is far below one second.
 */
`ifndef NIC_MACROS_SVH
`define NIC_MACROS_SVH

// Bus and field widths
`define NIC_MMIO_ADDR_W  16
`define NIC_MMIO_DATA_W  64
`define NIC_TID_W        9
`define NIC_CL_ADDR_W    42
`define NIC_LMAX_FLOWS   3
`define NIC_LMAX_RXQ     3
`define NIC_LMAX_BATCH   4
`define NIC_LMAX_POLL    8
`define NIC_RATE_W       32
`define NIC_CNT_W        64

// Rate meter window in ccip_clk cycles
`define NIC_RPS_WINDOW   64

`define NIC_AFU_ID       128'h9c2a_71f4_03be_4d8e_a5c1_6f20_e7d9_3b58

// MMIO register map
`define NIC_A_DFH          16'd0
`define NIC_A_AFU_ID_L     16'd2
`define NIC_A_AFU_ID_H     16'd4
`define NIC_A_TX_ADDR      16'd16
`define NIC_A_RX_ADDR      16'd18
`define NIC_A_START        16'd20
`define NIC_A_FLOWS        16'd22
`define NIC_A_INIT         16'd24
`define NIC_A_STATUS       16'd26
`define NIC_A_RPS          16'd28
`define NIC_A_GET_CNT      16'd30
`define NIC_A_PCK_CNT      16'd32
`define NIC_A_RXQ          16'd34
`define NIC_A_TX_BATCH     16'd36
`define NIC_A_POLL         16'd38
`define NIC_A_CONN_SETUP   16'd40
`define NIC_A_CONN_STATUS  16'd42

`endif

// ==== nic_monitor.sv ====
/*
 * NIC status register and request-rate meter.
 * Status follows its inputs with one cycle of latency. The rate is the number
 * of rpc_in strobes in the last complete window of NIC_RPS_WINDOW cycles.
 */
`timescale 1ns/1ps
`include "nic_macros.svh"

module nic_monitor
    import nic_pkg::*;
#(
    parameter int NIC_ID = 0
) (
    input  logic        ccip_clk,
    input  logic        reset,
    input  logic        nic_start,
    input  logic        ccip_initialized,
    input  logic        rpc_initialized,
    input  logic        ccip_error,
    input  logic        rpc_error,

    nic_event_if.sink   ev,
    nic_readback_if.mon rb
);

    localparam int WIN_W = $clog2(`NIC_RPS_WINDOW);

    logic                   system_ready;
    nic_status_t            status_q;
    logic [WIN_W-1:0]       win_cnt;
    logic [`NIC_RATE_W-1:0] req_cnt;
    logic [`NIC_RATE_W-1:0] rps_q;

    assign system_ready = ccip_initialized & rpc_initialized;

    // ========================================================================
    // Status
    // ========================================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            status_q <= '0;
        end else begin
            status_q.nic_id   <= 4'(NIC_ID);
            status_q.ready    <= system_ready;
            status_q.running  <= system_ready & nic_start;
            status_q.err_ccip <= ccip_error;
            status_q.err_rpc  <= rpc_error;
            status_q.error    <= ccip_error | rpc_error;
        end
    end

    // ========================================================================
    // Rate meter
    // ========================================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            win_cnt <= '0;
            req_cnt <= '0;
            rps_q   <= '0;
        end else if (win_cnt == WIN_W'(`NIC_RPS_WINDOW - 1)) begin
            // Last cycle of the window still counts
            rps_q   <= req_cnt + `NIC_RATE_W'(ev.rpc_in);
            req_cnt <= '0;
            win_cnt <= '0;
        end else begin
            if (ev.rpc_in) begin
                req_cnt <= req_cnt + 1'b1;
            end
            win_cnt <= win_cnt + 1'b1;
        end
    end

    assign rb.status = status_q;
    assign rb.rps    = rps_q;

endmodule

// ==== nic_pkg.sv ====
/*
 * Shared types of the NIC control plane.
 * Field order is MSB first, matching the bit layout seen by the host.
 */
`include "nic_macros.svh"

package nic_pkg;

    // One MMIO data word
    typedef logic [`NIC_MMIO_DATA_W-1:0] mmio_word_t;

    // NIC status as read back at STATUS
    typedef struct packed {
        logic [3:0] nic_id;
        logic       ready;
        logic       running;
        logic       err_ccip;
        logic       err_rpc;
        // OR of all error sources
        logic       error;
    } nic_status_t;

    // Connection setup request written by the host
    typedef struct packed {
        logic [31:0] client_ip;
        logic [15:0] client_port;
        logic [15:0] conn_id;
    } conn_setup_frame_t;

    // Result of a connection setup, returned by the RPC layer
    typedef struct packed {
        logic        valid;
        logic [15:0] conn_id;
        logic        failed;
    } conn_status_t;

    // MMIO write data, seen either raw or as a setup frame
    typedef union packed {
        mmio_word_t        raw;
        conn_setup_frame_t frame;
    } mmio_data_u;

endpackage

// ==== nic_pkt_counters.sv ====
/*
 * Four free-running packet counters selected through cnt_sel.
 * Ids 0..3 are rpc_in, rpc_out, net_tx and net_rx. Other ids read zero.
 * Counters wrap silently at 2**NIC_CNT_W.
 */
`timescale 1ns/1ps
`include "nic_macros.svh"

module nic_pkt_counters (
    input  logic        ccip_clk,
    input  logic        reset,

    nic_event_if.sink   ev,
    nic_readback_if.cnt rb
);

    localparam int NUM_CNT = 4;

    logic [NUM_CNT-1:0]    strobe;
    logic [`NIC_CNT_W-1:0] cnt_q [NUM_CNT];

    // Bit position is the counter id
    assign strobe = {ev.net_rx, ev.net_tx, ev.rpc_out, ev.rpc_in};

    for (genvar i = 0; i < NUM_CNT; i++) begin : g_cnt
        always_ff @(posedge ccip_clk) begin
            if (reset) begin
                cnt_q[i] <= '0;
            end else if (strobe[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    // Selected counter, zero for unknown ids
    always_comb begin
        if (rb.cnt_sel < 8'(NUM_CNT)) begin
            rb.cnt_value = cnt_q[rb.cnt_sel[1:0]];
        end else begin
            rb.cnt_value = '0;
        end
    end

endmodule

// ==== nic_top.sv ====
/*
 * NIC control and monitoring plane, all on ccip_clk.
 * Request, packet, init and error inputs are plain levels or strobes from
 * the transport and RPC layers, which sit outside this block.
 */
`timescale 1ns/1ps
`include "nic_macros.svh"

module nic_top
    import nic_pkg::*;
#(
    parameter int NIC_ID = 0
) (
    input  logic                         ccip_clk,
    input  logic                         reset,

    // Host MMIO
    input  logic                         mmio_rd_valid,
    input  logic                         mmio_wr_valid,
    input  logic [`NIC_MMIO_ADDR_W-1:0]  mmio_addr,
    input  logic [`NIC_TID_W-1:0]        mmio_tid,
    input  logic [`NIC_MMIO_DATA_W-1:0]  mmio_wr_data,
    output logic                         mmio_rsp_valid,
    output logic [`NIC_TID_W-1:0]        mmio_rsp_tid,
    output logic [`NIC_MMIO_DATA_W-1:0]  mmio_rsp_data,

    // Configuration
    output logic [`NIC_CL_ADDR_W-1:0]    mem_tx_addr,
    output logic [`NIC_CL_ADDR_W-1:0]    mem_rx_addr,
    output logic                         nic_start,
    output logic [`NIC_LMAX_FLOWS-1:0]   num_of_flows,
    output logic [`NIC_LMAX_RXQ-1:0]     rx_queue_size,
    output logic [`NIC_LMAX_BATCH-1:0]   tx_batch_size,
    output logic [`NIC_LMAX_POLL-1:0]    polling_rate,
    output logic                         nic_init,

    // Connection setup towards the RPC layer
    output logic                         conn_setup_valid,
    output conn_setup_frame_t            conn_setup_frame,
    input  logic                         conn_status_valid,
    input  conn_status_t                 conn_status_in,

    // Layer state
    input  logic                         ccip_initialized,
    input  logic                         rpc_initialized,
    input  logic                         ccip_error,
    input  logic                         rpc_error,

    // Event strobes
    input  logic                         rpc_in_valid,
    input  logic                         rpc_out_valid,
    input  logic                         net_tx_valid,
    input  logic                         net_rx_valid
);

    nic_event_if    ev ();
    nic_readback_if rb ();

    assign ev.rpc_in  = rpc_in_valid;
    assign ev.rpc_out = rpc_out_valid;
    assign ev.net_tx  = net_tx_valid;
    assign ev.net_rx  = net_rx_valid;

    nic_csr nic_csr_i (
        .ccip_clk          (ccip_clk),
        .reset             (reset),
        .mmio_rd_valid     (mmio_rd_valid),
        .mmio_wr_valid     (mmio_wr_valid),
        .mmio_addr         (mmio_addr),
        .mmio_tid          (mmio_tid),
        .mmio_wr_data      (mmio_data_u'(mmio_wr_data)),
        .conn_status_valid (conn_status_valid),
        .conn_status_in    (conn_status_in),
        .mmio_rsp_valid    (mmio_rsp_valid),
        .mmio_rsp_tid      (mmio_rsp_tid),
        .mmio_rsp_data     (mmio_rsp_data),
        .mem_tx_addr       (mem_tx_addr),
        .mem_rx_addr       (mem_rx_addr),
        .nic_start         (nic_start),
        .num_of_flows      (num_of_flows),
        .rx_queue_size     (rx_queue_size),
        .tx_batch_size     (tx_batch_size),
        .polling_rate      (polling_rate),
        .nic_init          (nic_init),
        .conn_setup_valid  (conn_setup_valid),
        .conn_setup_frame  (conn_setup_frame),
        .rb                (rb.csr)
    );

    nic_monitor #(
        .NIC_ID (NIC_ID)
    ) nic_monitor_i (
        .ccip_clk         (ccip_clk),
        .reset            (reset),
        .nic_start        (nic_start),
        .ccip_initialized (ccip_initialized),
        .rpc_initialized  (rpc_initialized),
        .ccip_error       (ccip_error),
        .rpc_error        (rpc_error),
        .ev               (ev.sink),
        .rb               (rb.mon)
    );

    nic_pkt_counters nic_pkt_counters_i (
        .ccip_clk (ccip_clk),
        .reset    (reset),
        .ev       (ev.sink),
        .rb       (rb.cnt)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the NIC control plane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_nic_top -o sim_nic

sim_status=0
./obj_dir/sim_nic > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$sim_status" -ne 0 ] \
    || ! grep -q "Simulation completed successfully" sim.log; then
    echo "run_sim: testbench reported a failure"
    exit 1
fi
echo "run_sim: testbench passed"

// ==== tb_nic_properties.sv ====
/*
 * Timing rules of the NIC control plane, bound into nic_top.
 * Rules are checked only while reset is low.
 */
`timescale 1ns/1ps

module tb_nic_properties
    import nic_pkg::*;
(
    input logic        ccip_clk,
    input logic        reset,
    input logic        mmio_rd_valid,
    input logic        mmio_rsp_valid,
    input logic        nic_init,
    input logic        conn_setup_valid,
    input nic_status_t status
);

    // Read response exactly one cycle after the request
    rsp_follows_read: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_rd_valid |=> mmio_rsp_valid)
        else $error("MMIO read was not answered in the next cycle");

    rsp_only_after_read: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_rsp_valid |-> $past(mmio_rd_valid))
        else $error("MMIO response appeared without a read one cycle before");

    init_two_cycles: assert property (@(posedge ccip_clk) disable iff (reset)
        $rose(nic_init) |=> nic_init ##1 !nic_init)
        else $error("nic_init did not last exactly two cycles");

    // Single-cycle strobe
    setup_single_cycle: assert property (@(posedge ccip_clk) disable iff (reset)
        conn_setup_valid |=> !conn_setup_valid)
        else $error("conn_setup_valid stayed high for more than one cycle");

    running_needs_ready: assert property (@(posedge ccip_clk) disable iff (reset)
        status.running |-> status.ready)
        else $error("Status shows running while not ready");

endmodule

// ==== tb_nic_top.sv ====
/*
 * Testbench for the NIC control plane, one nic_top with NIC_ID 5.
 * Inputs change on the falling edge and outputs are sampled there too.
 * Counter and rate checks assume rpc_in stays low until they run.
 */
`timescale 1ns/1ps
`include "nic_macros.svh"

module tb_nic_top
    import nic_pkg::*;
();

    localparam int RATE_WIN = `NIC_RPS_WINDOW;
    localparam logic [127:0] AFU_ID = `NIC_AFU_ID;
    localparam logic [1:0] OP_RD = 2'd0;
    localparam logic [1:0] OP_CFG = 2'd1;
    localparam logic [1:0] OP_STAT = 2'd2;

    // One table row: operation, address, write data, expected value
    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] addr;
        mmio_word_t  data;
        mmio_word_t  exp;
    } step_t;

    logic ccip_clk = 1'b0;
    logic reset;
    logic mmio_rd_valid, mmio_wr_valid, mmio_rsp_valid;
    logic [`NIC_MMIO_ADDR_W-1:0] mmio_addr;
    logic [`NIC_TID_W-1:0] mmio_tid, mmio_rsp_tid;
    mmio_word_t mmio_wr_data, mmio_rsp_data;
    logic [`NIC_CL_ADDR_W-1:0] mem_tx_addr, mem_rx_addr;
    logic nic_start, nic_init, conn_setup_valid, conn_status_valid;
    logic [`NIC_LMAX_FLOWS-1:0] num_of_flows;
    logic [`NIC_LMAX_RXQ-1:0] rx_queue_size;
    logic [`NIC_LMAX_BATCH-1:0] tx_batch_size;
    logic [`NIC_LMAX_POLL-1:0] polling_rate;
    conn_setup_frame_t conn_setup_frame;
    conn_status_t conn_status_in;
    logic ccip_initialized, rpc_initialized, ccip_error, rpc_error;
    logic rpc_in_valid, rpc_out_valid, net_tx_valid, net_rx_valid;

    step_t steps[$];
    bit    table_ready = 1'b0;
    int    n_pass = 0;
    int    n_fail = 0;

    always #4 ccip_clk = ~ccip_clk;

    nic_top #(.NIC_ID(5)) nic_top_i (
        .ccip_clk(ccip_clk), .reset(reset),
        .mmio_rd_valid(mmio_rd_valid), .mmio_wr_valid(mmio_wr_valid),
        .mmio_addr(mmio_addr), .mmio_tid(mmio_tid), .mmio_wr_data(mmio_wr_data),
        .mmio_rsp_valid(mmio_rsp_valid), .mmio_rsp_tid(mmio_rsp_tid),
        .mmio_rsp_data(mmio_rsp_data),
        .mem_tx_addr(mem_tx_addr), .mem_rx_addr(mem_rx_addr), .nic_start(nic_start),
        .num_of_flows(num_of_flows), .rx_queue_size(rx_queue_size),
        .tx_batch_size(tx_batch_size), .polling_rate(polling_rate), .nic_init(nic_init),
        .conn_setup_valid(conn_setup_valid), .conn_setup_frame(conn_setup_frame),
        .conn_status_valid(conn_status_valid), .conn_status_in(conn_status_in),
        .ccip_initialized(ccip_initialized), .rpc_initialized(rpc_initialized),
        .ccip_error(ccip_error), .rpc_error(rpc_error),
        .rpc_in_valid(rpc_in_valid), .rpc_out_valid(rpc_out_valid),
        .net_tx_valid(net_tx_valid), .net_rx_valid(net_rx_valid)
    );

    bind nic_top tb_nic_properties props_i (
        .ccip_clk(ccip_clk), .reset(reset), .mmio_rd_valid(mmio_rd_valid),
        .mmio_rsp_valid(mmio_rsp_valid), .nic_init(nic_init),
        .conn_setup_valid(conn_setup_valid), .status(rb.status)
    );

    // ========================================================================
    // Result bookkeeping and compare tasks
    // ========================================================================
    task automatic report(input bit ok, input string name, input string detail);
        if (ok) begin
            n_pass++;
            $display("PASS %s", name);
        end else begin
            n_fail++;
            $display("MISMATCH at %0t: %s %s", $time, name, detail);
        end
    endtask

    task automatic compare_word(input string name, input mmio_word_t got, input mmio_word_t exp);
        report(got === exp, name, $sformatf("got %h expected %h", got, exp));
    endtask

    task automatic compare_status(input string name, input nic_status_t got,
                                  input nic_status_t exp);
        report(got === exp, name, $sformatf("got %b expected %b", got, exp));
    endtask

    task automatic compare_frame(input string name, input conn_setup_frame_t got,
                                 input conn_setup_frame_t exp);
        report(got === exp, name, $sformatf("got %h expected %h", got, exp));
    endtask

    task automatic compare_config(input string name, input logic [`NIC_CL_ADDR_W-1:0] got,
                                  input logic [`NIC_CL_ADDR_W-1:0] exp);
        report(got === exp, name, $sformatf("got %h expected %h", got, exp));
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        report(got == exp, name, $sformatf("got %0d cycles expected %0d", got, exp));
    endtask

    // ========================================================================
    // MMIO access
    // ========================================================================
    task automatic mmio_write(input logic [15:0] addr, input mmio_word_t data);
        mmio_wr_valid = 1'b1;
        mmio_addr     = addr;
        mmio_wr_data  = data;
        @(negedge ccip_clk);
        mmio_wr_valid = 1'b0;
    endtask

    task automatic mmio_read(input logic [15:0] addr, output mmio_word_t data);
        logic [`NIC_TID_W-1:0] tag;
        int waited;
        tag = 9'($urandom);
        waited = 0;
        mmio_rd_valid = 1'b1;
        mmio_addr     = addr;
        mmio_tid      = tag;
        @(negedge ccip_clk);
        mmio_rd_valid = 1'b0;
        while (!mmio_rsp_valid && waited < 4) begin
            @(negedge ccip_clk);
            waited++;
        end
        data = mmio_rsp_data;
        if (!mmio_rsp_valid) begin
            n_fail++;
            $display("No MMIO response arrived for the read of address %0d", addr);
        end else if (mmio_rsp_tid !== tag) begin
            n_fail++;
            $display("MISMATCH at %0t: tag of read %0d got %0d expected %0d",
                     $time, addr, mmio_rsp_tid, tag);
        end
    endtask

    task automatic read_check(input string name, input logic [15:0] addr,
                              input mmio_word_t exp);
        mmio_word_t got;
        mmio_read(addr, got);
        compare_word(name, got, exp);
    endtask

    task automatic set_event(input int id, input logic value);
        case (id)
            0: rpc_in_valid = value;
            1: rpc_out_valid = value;
            2: net_tx_valid = value;
            default: net_rx_valid = value;
        endcase
    endtask

    function automatic logic [`NIC_CL_ADDR_W-1:0] cfg_output(input logic [15:0] addr);
        case (addr)
            `NIC_A_TX_ADDR:  return mem_tx_addr;
            `NIC_A_RX_ADDR:  return mem_rx_addr;
            `NIC_A_FLOWS:    return 42'(num_of_flows);
            `NIC_A_RXQ:      return 42'(rx_queue_size);
            `NIC_A_TX_BATCH: return 42'(tx_batch_size);
            `NIC_A_POLL:     return 42'(polling_rate);
            default:         return 42'(nic_start);
        endcase
    endfunction

    // Status bits in: {start, ccip_init, rpc_init, ccip_err, rpc_err}
    function automatic nic_status_t expected_status(input logic [4:0] in_bits);
        nic_status_t s;
        s.nic_id   = 4'd5;
        s.ready    = in_bits[3] & in_bits[2];
        s.running  = s.ready & in_bits[4];
        s.err_ccip = in_bits[1];
        s.err_rpc  = in_bits[0];
        s.error    = in_bits[1] | in_bits[0];
        return s;
    endfunction

    function automatic mmio_word_t rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic void add_step(input logic [1:0] op, input logic [15:0] addr,
                                     input mmio_word_t data, input mmio_word_t exp);
        steps.push_back('{op, addr, data, exp});
    endfunction

    // ========================================================================
    // Stimulus table
    // ========================================================================
    function automatic void build_table();
        mmio_word_t d;
        logic [`NIC_LMAX_FLOWS-1:0] minus_one;
        logic [4:0] stat_rows [6] = '{5'b11100, 5'b01100, 5'b11000, 5'b00010,
                                      5'b00001, 5'b11111};
        add_step(OP_RD, `NIC_A_RPS, '0, '0);
        add_step(OP_RD, `NIC_A_PCK_CNT, '0, '0);
        add_step(OP_RD, `NIC_A_DFH, '0, {4'h1, 19'd0, 1'b1, 40'd0});
        add_step(OP_RD, `NIC_A_AFU_ID_L, '0, AFU_ID[63:0]);
        add_step(OP_RD, `NIC_A_AFU_ID_H, '0, AFU_ID[127:64]);
        add_step(OP_RD, 16'd6, '0, '0);
        add_step(OP_RD, 16'd100, '0, '0);
        d = rand64();
        add_step(OP_CFG, `NIC_A_TX_ADDR, d, 64'(d[`NIC_CL_ADDR_W-1:0]));
        d = rand64();
        add_step(OP_CFG, `NIC_A_RX_ADDR, d, 64'(d[`NIC_CL_ADDR_W-1:0]));
        // Host writes a count, the register holds count minus one
        d = rand64();
        minus_one = d[`NIC_LMAX_FLOWS-1:0] - 3'd1;
        add_step(OP_CFG, `NIC_A_FLOWS, d, 64'(minus_one));
        d = rand64();
        minus_one = d[`NIC_LMAX_RXQ-1:0] - 3'd1;
        add_step(OP_CFG, `NIC_A_RXQ, d, 64'(minus_one));
        d = rand64();
        add_step(OP_CFG, `NIC_A_TX_BATCH, d, 64'(d[`NIC_LMAX_BATCH-1:0]));
        d = rand64();
        add_step(OP_CFG, `NIC_A_POLL, d, 64'(d[`NIC_LMAX_POLL-1:0]));
        // Start keeps only bit 0
        d = rand64();
        add_step(OP_CFG, `NIC_A_START, d, 64'(d[0]));
        foreach (stat_rows[i]) begin
            add_step(OP_STAT, `NIC_A_STATUS, 64'(stat_rows[i]),
                     64'(expected_status(stat_rows[i])));
        end
    endfunction

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        step_t             st;
        mmio_word_t        got;
        mmio_word_t        w;
        conn_setup_frame_t exp_frame;
        conn_status_t      cs;
        int                pulses;
        int                n_ev [4];
        void'($urandom(25));
        reset = 1'b1;
        {mmio_rd_valid, mmio_wr_valid, mmio_addr, mmio_tid, mmio_wr_data} = '0;
        {conn_status_valid, conn_status_in} = '0;
        {ccip_initialized, rpc_initialized, ccip_error, rpc_error} = '0;
        {rpc_in_valid, rpc_out_valid, net_tx_valid, net_rx_valid} = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(negedge ccip_clk);
        reset = 1'b0;
        compare_config("outputs low after reset",
                       42'({mmio_rsp_valid, nic_start, nic_init, conn_setup_valid}), '0);

        for (int i = 0; i < steps.size(); i++) begin
            st = steps[i];
            case (st.op)
                OP_RD: read_check($sformatf("read of address %0d", st.addr), st.addr, st.exp);
                OP_CFG: begin
                    mmio_write(st.addr, st.data);
                    compare_config($sformatf("config at address %0d", st.addr),
                                   cfg_output(st.addr), st.exp[`NIC_CL_ADDR_W-1:0]);
                end
                default: begin
                    {ccip_initialized, rpc_initialized, ccip_error, rpc_error} = st.data[3:0];
                    mmio_write(`NIC_A_START, 64'(st.data[4]));
                    // Status lags nic_start by one more cycle
                    @(negedge ccip_clk);
                    mmio_read(`NIC_A_STATUS, got);
                    compare_status($sformatf("status for inputs %b", st.data[4:0]),
                                   nic_status_t'(got[8:0]), nic_status_t'(st.exp[8:0]));
                end
            endcase
        end

        mmio_write(`NIC_A_INIT, '0);
        pulses = 0;
        repeat (5) begin
            if (nic_init) pulses++;
            @(negedge ccip_clk);
        end
        compare_count("init pulse length", pulses, 2);

        w = rand64();
        exp_frame.client_ip   = w[63:32];
        exp_frame.client_port = w[31:16];
        exp_frame.conn_id     = w[15:0];
        mmio_write(`NIC_A_CONN_SETUP, w);
        compare_frame("conn setup frame", conn_setup_frame, exp_frame);
        pulses = 0;
        repeat (4) begin
            if (conn_setup_valid) pulses++;
            @(negedge ccip_clk);
        end
        compare_count("conn setup strobe length", pulses, 1);

        cs.valid   = 1'b1;
        cs.conn_id = 16'($urandom);
        cs.failed  = 1'($urandom);
        conn_status_in    = cs;
        conn_status_valid = 1'b1;
        @(negedge ccip_clk);
        conn_status_valid = 1'b0;
        read_check("conn status first read", `NIC_A_CONN_STATUS, 64'(cs));
        read_check("conn status after clear", `NIC_A_CONN_STATUS, '0);

        // Each event held high for a random number of cycles
        for (int id = 0; id < 4; id++) begin
            n_ev[id] = int'($urandom_range(16, 1));
            set_event(id, 1'b1);
            repeat (n_ev[id]) @(negedge ccip_clk);
            set_event(id, 1'b0);
        end
        for (int id = 0; id < 4; id++) begin
            mmio_write(`NIC_A_GET_CNT, 64'(id));
            read_check($sformatf("packet counter %0d", id), `NIC_A_PCK_CNT, 64'(n_ev[id]));
        end
        mmio_write(`NIC_A_GET_CNT, 64'd6);
        read_check("packet counter id 6", `NIC_A_PCK_CNT, '0);

        rpc_in_valid = 1'b1;
        repeat (2 * RATE_WIN) @(negedge ccip_clk);
        read_check("rate with rpc_in high", `NIC_A_RPS, 64'(RATE_WIN));
        rpc_in_valid = 1'b0;
        repeat (2 * RATE_WIN) @(negedge ccip_clk);
        read_check("rate with rpc_in low", `NIC_A_RPS, '0);

        $display("Summary: %0d checks passed, %0d checks failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the table length and the rate windows
    initial begin
        int limit;
        wait (table_ready);
        limit = steps.size() * 20 + 4 * RATE_WIN + 100;
        repeat (limit) @(posedge ccip_clk);
        $display("Watchdog expired: the run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
nic_pkg.sv
nic_if.sv
nic_csr.sv
nic_monitor.sv
nic_pkt_counters.sv
nic_top.sv
tb_nic_properties.sv
tb_nic_top.sv
